// ==== design/floor_logic_settings.svh ====
`ifndef FLOOR_LOGIC_SETTINGS_SVH
`define FLOOR_LOGIC_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// Building dimensions
//////////////////////////////////////////////////////////////////////

// Floors served by the car
`define FLOOR_COUNT 11

// Bits of a floor number, floor 1 is encoded as 0
`define FLOOR_WIDTH 4

// Request queue, must hold at least one entry per floor
`define QUEUE_DEPTH 11

// Bits of a queue read or write pointer
`define QPTR_WIDTH 4

`endif

// ==== design/floor_logic_pkg.sv ====
`include "floor_logic_settings.svh"

package floor_logic_pkg;

    //////////////////////////////////////////////////////////////////////
    // Scalar types
    //////////////////////////////////////////////////////////////////////

    // Floor number, 0 is floor 1
    typedef logic [`FLOOR_WIDTH-1:0] floor_t;

    // One bit per floor, bit 0 is floor 1
    typedef logic [`FLOOR_COUNT-1:0] floor_mask_t;

    // Read or write position in the request queue
    typedef logic [`QPTR_WIDTH-1:0] qptr_t;

    //////////////////////////////////////////////////////////////////////
    // Bundles
    //////////////////////////////////////////////////////////////////////

    // Hall call and car panel, used for buttons and their lamps
    typedef struct packed {
        floor_mask_t call;
        floor_mask_t panel;
    } button_bank_t;

    // Position and motion reported by the elevator FSM
    typedef struct packed {
        floor_t current_floor;
        logic   moving;
    } car_status_t;

    // Single cycle floor event
    typedef struct packed {
        logic   valid;
        floor_t floor;
    } floor_strobe_t;

endpackage

// ==== design/floor_request_latch.sv ====
`timescale 1ns/1ns

module floor_request_latch
    import floor_logic_pkg::*;
(
    input  logic          clock,
    input  logic          reset_n,
    input  button_bank_t  buttons,
    input  car_status_t   car,
    input  logic          emergency_btn,
    input  logic          power_switch,
    input  floor_strobe_t served,
    output button_bank_t  lights,
    output floor_strobe_t new_request
);

    localparam int FLOORS = $bits(floor_mask_t);

    // Floors lit but not yet handed to the queue
    floor_mask_t pending;

    floor_mask_t car_mask;
    floor_mask_t open_mask;
    floor_mask_t served_mask;
    floor_mask_t accept_call;
    floor_mask_t accept_panel;
    floor_mask_t new_floors;
    floor_mask_t release_mask;

    //////////////////////////////////////////////////////////////////////
    // Press acceptance
    //////////////////////////////////////////////////////////////////////

    assign car_mask    = floor_mask_t'(1) << car.current_floor;
    assign served_mask = served.valid ? (floor_mask_t'(1) << served.floor) : '0;

    // No requests while stopped by emergency or with power off
    assign open_mask = (power_switch && !emergency_btn) ? ~car_mask : '0;

    assign accept_call  = buttons.call  & ~lights.call  & open_mask;
    assign accept_panel = buttons.panel & ~lights.panel & open_mask;

    // Only a floor with both lamps dark is new to the queue
    assign new_floors = (accept_call | accept_panel) & ~lights.call & ~lights.panel;

    //////////////////////////////////////////////////////////////////////
    // Release of the lowest pending floor
    //////////////////////////////////////////////////////////////////////

    // Isolate the lowest set bit
    assign release_mask = pending & (~pending + 1'b1);

    always_comb begin
        new_request.valid = |pending;
        new_request.floor = '0;
        for (int i = 0; i < FLOORS; i++) begin
            if (release_mask[i]) begin
                new_request.floor = floor_t'(i);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Lamp and pending registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lights  <= '0;
            pending <= '0;
        end else if (!power_switch) begin
            // Power off drops every request
            lights  <= '0;
            pending <= '0;
        end else begin
            lights.call  <= (lights.call  | accept_call)  & ~served_mask;
            lights.panel <= (lights.panel | accept_panel) & ~served_mask;
            pending      <= ((pending & ~release_mask) | new_floors) & ~served_mask;
        end
    end

endmodule

// ==== design/floor_request_queue.sv ====
`timescale 1ns/1ns

`include "floor_logic_settings.svh"

module floor_request_queue
    import floor_logic_pkg::*;
(
    input  logic          clock,
    input  logic          reset_n,
    input  logic          power_switch,
    input  floor_strobe_t new_request,
    input  floor_strobe_t served,
    output logic          head_valid,
    output floor_t        head
);

    // Target floors in order of arrival
    floor_t entries [`QUEUE_DEPTH];

    qptr_t rd_ptr;
    qptr_t wr_ptr;
    logic [`QPTR_WIDTH:0] count;

    logic push;
    logic pop;

    // Circular increment over the queue depth
    function automatic qptr_t next_ptr(input qptr_t ptr);
        if (ptr == qptr_t'(`QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign push = new_request.valid;
    assign pop  = served.valid;

    //////////////////////////////////////////////////////////////////////
    // Head of queue
    //////////////////////////////////////////////////////////////////////

    assign head_valid = (count != '0);

    // Reads floor 1 while empty
    assign head = head_valid ? entries[rd_ptr] : '0;

    //////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (push && power_switch) begin
            entries[wr_ptr] <= new_request.floor;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (!power_switch) begin
            // Flush while power is off
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Simultaneous push and pop leaves the count unchanged
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== design/car_dispatch.sv ====
`timescale 1ns/1ns

module car_dispatch
    import floor_logic_pkg::*;
(
    input  logic          clock,
    input  logic          reset_n,
    input  car_status_t   car,
    input  logic          head_valid,
    input  floor_t        head,
    input  logic          emergency_btn,
    input  logic          power_switch,
    input  logic          door_open_btn,
    input  logic          door_close_btn,
    output floor_strobe_t served,
    output logic          activate_elevator,
    output logic          direction_selector,
    output logic          door_open_allowed,
    output logic          door_close_allowed
);

    logic launch;
    logic doors_ok;

    //////////////////////////////////////////////////////////////////////
    // Arrival at the target floor
    //////////////////////////////////////////////////////////////////////

    assign served.valid = head_valid && !car.moving && (head == car.current_floor);
    assign served.floor = head;

    // Car standing elsewhere with a target waiting
    assign launch = head_valid && power_switch && !emergency_btn && !car.moving &&
                    (head != car.current_floor);

    assign doors_ok = !car.moving && power_switch;

    //////////////////////////////////////////////////////////////////////
    // Registered commands to the elevator FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            activate_elevator  <= 1'b0;
            direction_selector <= 1'b0;
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end else begin
            activate_elevator <= launch;
            // Direction only changes with a new launch
            if (launch) begin
                direction_selector <= (head > car.current_floor);
            end
            door_open_allowed  <= doors_ok && door_open_btn;
            door_close_allowed <= doors_ok && door_close_btn;
        end
    end

endmodule

// ==== design/floor_logic_control_unit.sv ====
`timescale 1ns/1ns

module floor_logic_control_unit
    import floor_logic_pkg::*;
(
    input  logic         clock,
    input  logic         reset_n,

    // Buttons, active high while pressed
    input  button_bank_t buttons,
    input  logic         door_open_btn,
    input  logic         door_close_btn,
    input  logic         emergency_btn,
    input  logic         power_switch,

    // Status from the elevator FSM
    input  car_status_t  car,

    // Lamps behind the hall and car buttons
    output button_bank_t lights,

    // Commands to the elevator FSM
    output floor_t       elevator_floor_selector,
    output logic         direction_selector,
    output logic         activate_elevator,
    output logic         door_open_allowed,
    output logic         door_close_allowed
);

    floor_strobe_t new_request;
    floor_strobe_t served;
    logic          head_valid;
    floor_t        head;

    //////////////////////////////////////////////////////////////////////
    // Button lamps and new floor detection
    //////////////////////////////////////////////////////////////////////

    floor_request_latch latch_i (
        .clock         (clock),
        .reset_n       (reset_n),
        .buttons       (buttons),
        .car           (car),
        .emergency_btn (emergency_btn),
        .power_switch  (power_switch),
        .served        (served),
        .lights        (lights),
        .new_request   (new_request)
    );

    //////////////////////////////////////////////////////////////////////
    // Target floors in arrival order
    //////////////////////////////////////////////////////////////////////

    floor_request_queue queue_i (
        .clock        (clock),
        .reset_n      (reset_n),
        .power_switch (power_switch),
        .new_request  (new_request),
        .served       (served),
        .head_valid   (head_valid),
        .head         (head)
    );

    // Target floor goes straight from the queue head
    assign elevator_floor_selector = head;

    //////////////////////////////////////////////////////////////////////
    // Motion and door commands
    //////////////////////////////////////////////////////////////////////

    car_dispatch dispatch_i (
        .clock              (clock),
        .reset_n            (reset_n),
        .car                (car),
        .head_valid         (head_valid),
        .head               (head),
        .emergency_btn      (emergency_btn),
        .power_switch       (power_switch),
        .door_open_btn      (door_open_btn),
        .door_close_btn     (door_close_btn),
        .served             (served),
        .activate_elevator  (activate_elevator),
        .direction_selector (direction_selector),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 3
) (
    output logic clock,
    output logic reset_n
);

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;
    end

endmodule

// ==== verif/floor_logic_tb.sv ====
`timescale 1ns/1ns

`include "floor_logic_settings.svh"

module floor_logic_tb
    import floor_logic_pkg::*;
();

    localparam int FLOORS       = `FLOOR_COUNT;
    localparam int STEP_TIMEOUT = 40;

    logic          clock;
    logic          reset_n;
    button_bank_t  buttons;
    car_status_t   car;
    logic          door_open_btn;
    logic          door_close_btn;
    logic          emergency_btn;
    logic          power_switch;
    button_bank_t  lights;
    floor_t        elevator_floor_selector;
    logic          direction_selector;
    logic          activate_elevator;
    logic          door_open_allowed;
    logic          door_close_allowed;

    int            error_count;
    int            test_count;
    int            failed_tests;
    int            errors_at_test_start;
    logic [15:0]   lfsr;

    // Reference model of lamps, pending floors, queue and commands
    floor_mask_t   m_call;
    floor_mask_t   m_panel;
    floor_mask_t   m_pending;
    floor_t        m_queue [`QUEUE_DEPTH];
    int            m_count;
    logic          m_act;
    logic          m_dir;
    logic          m_door_open;
    logic          m_door_close;
    floor_t        exp_head;

    tb_clock_gen clock_gen_i (
        .clock   (clock),
        .reset_n (reset_n)
    );

    floor_logic_control_unit dut_i (
        .clock                   (clock),
        .reset_n                 (reset_n),
        .buttons                 (buttons),
        .car                     (car),
        .door_open_btn           (door_open_btn),
        .door_close_btn          (door_close_btn),
        .emergency_btn           (emergency_btn),
        .power_switch            (power_switch),
        .lights                  (lights),
        .elevator_floor_selector (elevator_floor_selector),
        .direction_selector      (direction_selector),
        .activate_elevator       (activate_elevator),
        .door_open_allowed       (door_open_allowed),
        .door_close_allowed      (door_close_allowed)
    );

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    assign exp_head = (m_count != 0) ? m_queue[0] : '0;

    always @(posedge clock or negedge reset_n) begin : reference_model
        floor_mask_t acc_call;
        floor_mask_t acc_panel;
        floor_mask_t new_floors;
        floor_mask_t next_pending;
        floor_mask_t served_mask;
        floor_t      next_queue [`QUEUE_DEPTH];
        int          next_count;
        int          release_floor;
        logic        floor_open;
        logic        serve;
        logic        launch;
        if (!reset_n) begin
            m_call       <= '0;
            m_panel      <= '0;
            m_pending    <= '0;
            m_queue      <= '{default: '0};
            m_count      <= 0;
            m_act        <= 1'b0;
            m_dir        <= 1'b0;
            m_door_open  <= 1'b0;
            m_door_close <= 1'b0;
        end else begin
            acc_call      = '0;
            acc_panel     = '0;
            new_floors    = '0;
            served_mask   = '0;
            release_floor = -1;
            for (int f = 0; f < FLOORS; f++) begin
                floor_open   = power_switch && !emergency_btn && (f != int'(car.current_floor));
                acc_call[f]  = buttons.call[f] && !m_call[f] && floor_open;
                acc_panel[f] = buttons.panel[f] && !m_panel[f] && floor_open;
                new_floors[f] = (acc_call[f] || acc_panel[f]) && !m_call[f] && !m_panel[f];
            end
            // Lowest pending floor goes to the queue
            for (int f = FLOORS - 1; f >= 0; f--) begin
                if (m_pending[f]) begin
                    release_floor = f;
                end
            end
            serve      = (m_count > 0) && !car.moving && (exp_head == car.current_floor);
            next_queue = m_queue;
            next_count = m_count;
            if (serve) begin
                served_mask[exp_head] = 1'b1;
                for (int i = 0; i < `QUEUE_DEPTH - 1; i++) begin
                    next_queue[i] = next_queue[i + 1];
                end
                next_count--;
            end
            next_pending = m_pending | new_floors;
            if (release_floor >= 0 && next_count < `QUEUE_DEPTH) begin
                next_pending[release_floor] = 1'b0;
                next_queue[next_count] = floor_t'(release_floor);
                next_count++;
            end
            if (!power_switch) begin
                m_call    <= '0;
                m_panel   <= '0;
                m_pending <= '0;
                m_count   <= 0;
            end else begin
                m_call    <= (m_call | acc_call) & ~served_mask;
                m_panel   <= (m_panel | acc_panel) & ~served_mask;
                m_pending <= next_pending & ~served_mask;
                m_queue   <= next_queue;
                m_count   <= next_count;
            end
            launch = (m_count > 0) && power_switch && !emergency_btn && !car.moving &&
                     (exp_head != car.current_floor);
            m_act <= launch;
            if (launch) begin
                m_dir <= (exp_head > car.current_floor);
            end
            m_door_open  <= !car.moving && power_switch && door_open_btn;
            m_door_close <= !car.moving && power_switch && door_close_btn;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output checks on the falling edge
    //////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t ns", name, got, expected, $time);
        error_count++;
    endtask

    assert property (@(negedge clock) disable iff (!reset_n) lights.call == m_call)
        else report_mismatch("lights.call", lights.call, m_call);
    assert property (@(negedge clock) disable iff (!reset_n) lights.panel == m_panel)
        else report_mismatch("lights.panel", lights.panel, m_panel);
    assert property (@(negedge clock) disable iff (!reset_n)
                     elevator_floor_selector == exp_head)
        else report_mismatch("elevator_floor_selector", elevator_floor_selector, exp_head);
    assert property (@(negedge clock) disable iff (!reset_n) activate_elevator == m_act)
        else report_mismatch("activate_elevator", activate_elevator, m_act);
    assert property (@(negedge clock) disable iff (!reset_n) direction_selector == m_dir)
        else report_mismatch("direction_selector", direction_selector, m_dir);
    assert property (@(negedge clock) disable iff (!reset_n) door_open_allowed == m_door_open)
        else report_mismatch("door_open_allowed", door_open_allowed, m_door_open);
    assert property (@(negedge clock) disable iff (!reset_n)
                     door_close_allowed == m_door_close)
        else report_mismatch("door_close_allowed", door_close_allowed, m_door_close);

    //////////////////////////////////////////////////////////////////////
    // Random source and helpers
    //////////////////////////////////////////////////////////////////////

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    function automatic logic [31:0] random_bits(input int width);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < width; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    function automatic floor_t random_floor();
        return floor_t'(random_bits(4) % FLOORS);
    endfunction

    // About one floor in eight set
    function automatic floor_mask_t sparse_mask();
        floor_mask_t mask;
        mask = floor_mask_t'(random_bits(FLOORS));
        mask = mask & floor_mask_t'(random_bits(FLOORS));
        return mask & floor_mask_t'(random_bits(FLOORS));
    endfunction

    task automatic abort_run(input string reason);
        $display("ERROR: %s at %0t ns", reason, $time);
        $display("Simulation FAILED");
        $finish;
    endtask

    task automatic wait_reset_release();
        int cycles;
        for (cycles = 0; cycles < STEP_TIMEOUT && !reset_n; cycles++) begin
            @(posedge clock);
        end
        if (!reset_n) begin
            abort_run("reset was never released");
        end
    endtask

    // Polls on falling edges, returns on a rising edge for the next drive
    task automatic wait_requests_queued();
        int cycles;
        @(negedge clock);
        for (cycles = 0; cycles < STEP_TIMEOUT && m_pending != '0; cycles++) begin
            @(negedge clock);
        end
        if (m_pending != '0) begin
            abort_run("pressed floors did not reach the queue in time");
        end
        @(posedge clock);
    endtask

    task automatic wait_floor_served(input floor_t target);
        int cycles;
        @(negedge clock);
        for (cycles = 0; cycles < STEP_TIMEOUT &&
             (lights.call[target] || lights.panel[target]); cycles++) begin
            @(negedge clock);
        end
        if (lights.call[target] || lights.panel[target]) begin
            abort_run("car stood at the target floor but its lamps stayed lit");
        end
        @(posedge clock);
    endtask

    task automatic idle_inputs();
        @(posedge clock);
        buttons        <= '0;
        door_open_btn  <= 1'b0;
        door_close_btn <= 1'b0;
        emergency_btn  <= 1'b0;
        power_switch   <= 1'b1;
    endtask

    task automatic power_cycle();
        @(posedge clock);
        buttons      <= '0;
        power_switch <= 1'b0;
        @(posedge clock);
        power_switch <= 1'b1;
    endtask

    task automatic begin_test();
        errors_at_test_start = error_count;
    endtask

    task automatic end_test(input string name);
        int errors;
        // Let the last driven cycle be checked
        @(negedge clock);
        #1;
        errors = error_count - errors_at_test_start;
        test_count++;
        if (errors != 0) begin
            failed_tests++;
        end
        $display("Test %0d %s: %s, %0d mismatches", test_count, name,
                 (errors == 0) ? "ok" : "failed", errors);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        floor_t target;
        buttons        = '0;
        car            = '0;
        door_open_btn  = 1'b0;
        door_close_btn = 1'b0;
        emergency_btn  = 1'b0;
        power_switch   = 1'b1;
        error_count    = 0;
        test_count     = 0;
        failed_tests   = 0;
        lfsr           = 16'd63943;
        wait_reset_release();

        begin_test();
        repeat (2) @(posedge clock);
        @(negedge clock);
        assert (lights == '0) else report_mismatch("lights", lights, 32'h0);
        assert (!activate_elevator) else report_mismatch("activate_elevator", 1, 0);
        assert (!direction_selector) else report_mismatch("direction_selector", 1, 0);
        assert (!door_open_allowed) else report_mismatch("door_open_allowed", 1, 0);
        assert (!door_close_allowed) else report_mismatch("door_close_allowed", 1, 0);
        end_test("reset state");

        // Presses mixed with emergency, power loss and a wandering car
        begin_test();
        for (int i = 0; i < 80; i++) begin
            @(posedge clock);
            buttons.call  <= sparse_mask();
            buttons.panel <= sparse_mask();
            emergency_btn <= (random_bits(3) == 0);
            power_switch  <= (random_bits(4) != 0);
            car.moving    <= (random_bits(1) != 0);
            if (random_bits(3) == 0) begin
                car.current_floor <= random_floor();
            end
        end
        idle_inputs();
        end_test("random presses");

        begin_test();
        power_cycle();
        @(posedge clock);
        car.current_floor <= '0;
        car.moving        <= 1'b1;
        @(posedge clock);
        buttons.call  <= 11'b100_0000_1000;
        buttons.panel <= 11'b000_0100_1000;
        @(posedge clock);
        buttons <= '0;
        wait_requests_queued();
        buttons.panel <= 11'b001_0000_0000;
        @(posedge clock);
        buttons <= '0;
        wait_requests_queued();
        buttons.call <= 11'b000_0000_0010;
        @(posedge clock);
        buttons <= '0;
        wait_requests_queued();
        end_test("arrival order");

        // Car moves onto the head floor, then stops there
        begin_test();
        for (int i = 0; i < FLOORS && m_count > 0; i++) begin
            @(posedge clock);
            car.moving        <= 1'b1;
            car.current_floor <= elevator_floor_selector;
            repeat (3) @(posedge clock);
            target = elevator_floor_selector;
            car.moving <= 1'b0;
            wait_floor_served(target);
        end
        end_test("serving");

        begin_test();
        @(posedge clock);
        car.current_floor <= random_floor();
        car.moving        <= 1'b0;
        for (int i = 0; i < 120; i++) begin
            @(posedge clock);
            if (random_bits(2) == 0) begin
                buttons.call  <= sparse_mask();
                buttons.panel <= sparse_mask();
            end else begin
                buttons <= '0;
            end
            emergency_btn <= (random_bits(3) == 0);
            car.moving    <= (random_bits(2) == 0);
            if (random_bits(2) == 0) begin
                car.current_floor <= random_floor();
            end
        end
        idle_inputs();
        end_test("dispatch");

        begin_test();
        for (int i = 0; i < 40; i++) begin
            @(posedge clock);
            door_open_btn  <= (random_bits(1) != 0);
            door_close_btn <= (random_bits(1) != 0);
            car.moving     <= (random_bits(2) == 0);
            power_switch   <= (random_bits(3) != 0);
        end
        idle_inputs();
        car.moving        <= 1'b1;
        car.current_floor <= '0;
        @(posedge clock);
        buttons.call  <= 11'b110_1010_0110;
        buttons.panel <= 11'b001_0001_0000;
        @(posedge clock);
        buttons <= '0;
        wait_requests_queued();
        power_switch <= 1'b0;
        @(posedge clock);
        power_switch <= 1'b1;
        @(negedge clock);
        assert (lights == '0) else report_mismatch("lights", lights, 32'h0);
        assert (elevator_floor_selector == '0)
            else report_mismatch("elevator_floor_selector", elevator_floor_selector, 32'h0);
        end_test("doors and power off");

        $display("Tests run: %0d, tests failed: %0d, mismatches: %0d",
                 test_count, failed_tests, error_count);
        if (error_count == 0 && failed_tests == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+design
design/floor_logic_pkg.sv
design/floor_request_latch.sv
design/floor_request_queue.sv
design/car_dispatch.sv
design/floor_logic_control_unit.sv
verif/tb_clock_gen.sv
verif/floor_logic_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the floor logic testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

TOP=floor_logic_tb
BUILD_DIR=build
OBJ_DIR=${BUILD_DIR}/obj
EXE_NAME=floor_logic_sim
LOG_FILE=${BUILD_DIR}/sim.log

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator was not found in PATH"
    exit 1
fi

if ! mkdir -p "${OBJ_DIR}"; then
    echo "could not create ${OBJ_DIR}"
    exit 1
fi

echo "Building ${TOP}"
if ! verilator --binary --timing --assert -Wno-fatal \
        -f project.f \
        --top-module "${TOP}" \
        --Mdir "${OBJ_DIR}" \
        -o "${EXE_NAME}"; then
    echo "Verilator build failed"
    exit 1
fi

echo "Running ${TOP}"
"./${OBJ_DIR}/${EXE_NAME}" > "${LOG_FILE}" 2>&1
run_status=$?
cat "${LOG_FILE}"

if [ ${run_status} -ne 0 ]; then
    echo "Simulator exited with status ${run_status}"
    exit 1
fi

# The log decides the result
if grep -q "Simulation FAILED" "${LOG_FILE}"; then
    exit 1
fi

exit 0
